//--- Makefile
# Verilator build and run of the co-processor testbench
VERILATOR ?= verilator
TOP       ?= tb_cop_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_clkgen.sv
// Testbench clock and reset source, reset held low for a few cycles
`timescale 1ns/1ps
module tb_clkgen #(
    parameter int half_period  = 50,    // 100 ns clock
    parameter int reset_cycles = 4
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #half_period g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (reset_cycles) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

endmodule

//--- bench/tb_cop_top.sv
// Directed testbench for the AES co-processor slice with reference S-box and MixColumns
`timescale 1ns/1ps
module tb_cop_top import aes_types_pkg::*, cop_isa_pkg::*; ();

    localparam int max_cycles = 700;    // About twice the summed test length

    logic        g_clk;
    logic        g_resetn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_done;
    logic        host_we;
    logic [3:0]  host_addr;
    logic [3:0]  host_raddr;
    aes_word_t   host_wdata;
    aes_word_t   host_rdata;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int unsigned seed_val;
    aes_byte_t   sbox_tab [256];    // Reference forward S-box
    aes_byte_t   inv_tab  [256];

    tb_clkgen #(.half_period(50), .reset_cycles(4)) u_clkgen (.g_clk, .g_resetn);

    cop_top #(.nregs(16)) uut (
        .g_clk, .g_resetn, .instr_valid, .instr, .instr_done,
        .host_we, .host_addr, .host_wdata, .host_raddr, .host_rdata
    );

    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t p;
        aes_byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Affine map written bit by bit from the standard matrix
    function automatic aes_byte_t affine(aes_byte_t b);
        aes_byte_t s;
        aes_byte_t c;
        c = 8'h63;
        for (int i = 0; i < 8; i++) begin
            s[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^
                   b[(i + 7) % 8] ^ c[i];
        end
        return s;
    endfunction

    // Field inverse by exhaustive search, inverse table by lookup
    task automatic build_models();
        aes_byte_t inv;
        for (int a = 0; a < 256; a++) begin
            inv = 8'h00;
            for (int b = 1; b < 256; b++) begin
                if (gf_mul(aes_byte_t'(a), aes_byte_t'(b)) == 8'h01) inv = aes_byte_t'(b);
            end
            sbox_tab[a] = affine(inv);
        end
        for (int a = 0; a < 256; a++) inv_tab[sbox_tab[a]] = aes_byte_t'(a);
    endtask

    function automatic aes_word_t sub_model(aes_word_t rs1, aes_word_t rs2, logic inv,
                                            logic rot);
        aes_word_t r;
        aes_byte_t src;
        r = '0;
        for (int k = 0; k < 4; k++) begin
            src = (k % 2 == 0) ? rs1[k] : rs2[k];    // Even steps read rs1
            if (rot) r[(k + 1) % 4] = inv ? inv_tab[src] : sbox_tab[src];
            else r[k] = inv ? inv_tab[src] : sbox_tab[src];
        end
        return r;
    endfunction

    function automatic aes_word_t mix_model(aes_word_t rs1, aes_word_t rs2, logic inv);
        aes_word_t r;
        aes_byte_t t [4];
        t[0] = rs1[0];
        t[1] = rs2[1];
        t[2] = rs1[2];
        t[3] = rs2[3];
        for (int k = 0; k < 4; k++) begin
            if (!inv)
                r[3 - k] = gf_mul(t[k], 8'h02) ^ gf_mul(t[(k + 1) % 4], 8'h03) ^
                           t[(k + 2) % 4] ^ t[(k + 3) % 4];
            else
                r[3 - k] = gf_mul(t[k], 8'h0e) ^ gf_mul(t[(k + 1) % 4], 8'h0b) ^
                           gf_mul(t[(k + 2) % 4], 8'h0d) ^ gf_mul(t[(k + 3) % 4], 8'h09);
        end
        return r;
    endfunction

    function automatic logic [31:0] make_instr(logic [3:0] cls, logic [4:0] sc,
                                               logic [3:0] rd, logic [3:0] rs1,
                                               logic [3:0] rs2);
        return {cls, sc, 7'd0, 4'd0, rd, rs2, rs1};
    endfunction

    task automatic check_word(input string what, input aes_word_t got, input aes_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input aes_word_t data);
        @(posedge g_clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge g_clk);
        host_we    <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output aes_word_t data);
        @(posedge g_clk);
        host_raddr <= addr;
        @(negedge g_clk);
        data = host_rdata;
    endtask

    // Hold the instruction until done, counting cycles of instr_valid
    task automatic issue(input logic [31:0] word, output int cycles);
        int n;
        n = 0;
        @(posedge g_clk);
        instr_valid <= 1'b1;
        instr       <= word;
        do begin
            @(negedge g_clk);
            n++;
        end while (instr_done !== 1'b1);
        @(posedge g_clk);
        instr_valid <= 1'b0;    // Writeback lands on this edge
        cycles = n;
    endtask

    task automatic run_op(input logic [4:0] sc, input logic [3:0] rd, input logic [3:0] rs1,
                          input logic [3:0] rs2, output aes_word_t result);
        int n;
        issue(make_instr(cls_aes, sc, rd, rs1, rs2), n);
        checks++;
        if (n != 4) begin
            errors++;
            $display("[FAIL] %0t ns: AES op done in cycle %0d, expected cycle 4", $time, n);
        end
        read_reg(rd, result);
    endtask

    task automatic test_reset();
        aes_word_t got;
        @(negedge g_clk);
        checks++;
        if (instr_done !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t ns: instr_done high after reset", $time);
        end
        for (int r = 0; r < 16; r++) begin
            read_reg(r[3:0], got);
            check_word("reset value", got, '0);
        end
    endtask

    task automatic test_sub();
        aes_word_t a;
        aes_word_t b;
        aes_word_t res;
        a = 32'h3c1f_a9d2;
        b = 32'h7e40_0b85;
        write_reg(4'd1, a);
        write_reg(4'd2, b);
        run_op(sclass_sub_enc, 4'd3, 4'd1, 4'd2, res);
        check_word("sub enc", res, sub_model(a, b, 1'b0, 1'b0));
        run_op(sclass_sub_dec, 4'd4, 4'd1, 4'd2, res);
        check_word("sub dec", res, sub_model(a, b, 1'b1, 1'b0));
    endtask

    task automatic test_rotate();
        aes_word_t a;
        aes_word_t b;
        aes_word_t res;
        a = 32'hd4e5_0167;
        b = 32'h9a2b_f830;
        write_reg(4'd1, a);
        write_reg(4'd2, b);
        run_op(sclass_sub_encrot, 4'd5, 4'd1, 4'd2, res);
        check_word("sub enc rot", res, sub_model(a, b, 1'b0, 1'b1));
        run_op(sclass_sub_decrot, 4'd6, 4'd1, 4'd2, res);
        check_word("sub dec rot", res, sub_model(a, b, 1'b1, 1'b1));
    endtask

    task automatic test_mix();
        aes_word_t res;
        aes_word_t col;
        write_reg(4'd8, 32'h4553_13db);    // Column db,13,53,45 from byte 0 up
        run_op(sclass_mix_enc, 4'd9, 4'd8, 4'd8, res);
        check_word("mix enc vector", res, 32'h8e4d_a1bc);
        check_word("mix enc model", res, mix_model(32'h4553_13db, 32'h4553_13db, 1'b0));
        col = {res[0], res[1], res[2], res[3]};    // Row 0 back into byte 0
        write_reg(4'd10, col);
        run_op(sclass_mix_dec, 4'd11, 4'd10, 4'd10, res);
        check_word("mix dec vector", res, 32'hdb13_5345);
        check_word("mix dec model", res, mix_model(col, col, 1'b1));
    endtask

    task automatic test_illegal();
        aes_word_t got;
        int n;
        write_reg(4'd12, 32'hcafe_0042);
        issue(make_instr(4'h3, sclass_sub_enc, 4'd12, 4'd1, 4'd2), n);
        checks++;
        if (n != 1) begin
            errors++;
            $display("[FAIL] %0t ns: illegal op done in cycle %0d, expected 1", $time, n);
        end
        read_reg(4'd12, got);
        check_word("illegal op dest", got, 32'hcafe_0042);
    endtask

    task automatic test_random();
        aes_word_t w;
        aes_word_t res;
        for (int i = 0; i < 20; i++) begin
            w = $urandom();
            write_reg(4'd13, w);
            run_op(sclass_sub_enc, 4'd14, 4'd13, 4'd13, res);
            check_word("random sub enc", res, sub_model(w, w, 1'b0, 1'b0));
            run_op(sclass_sub_dec, 4'd15, 4'd14, 4'd14, res);
            check_word("random round trip", res, w);
        end
    endtask

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        seed_val = 32'h29ba;
        void'($urandom(seed_val));
        instr_valid <= 1'b0;
        instr       <= '0;
        host_we     <= 1'b0;
        host_addr   <= '0;
        host_wdata  <= '0;
        host_raddr  <= '0;
        build_models();
        wait (g_resetn === 1'b1);
        test_reset();
        test_sub();
        test_rotate();
        test_mix();
        test_illegal();
        test_random();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- design/aes_sbox.sv
// AES S-box, forward and inverse, built from GF(2^8) inversion and the affine map
`timescale 1ns/1ps
module aes_sbox import aes_types_pkg::*; (
    input  aes_byte_t in,
    input  logic      inv,   // High selects the inverse S-box
    output aes_byte_t out
);

    aes_byte_t pre_inv;    // Input to the field inverter
    aes_byte_t inverted;

    // Rotate a byte left
    function automatic aes_byte_t rotl(aes_byte_t a, int n);
        return aes_byte_t'((a << n) | (a >> (8 - n)));
    endfunction

    // Full GF(2^8) product, shift-and-add
    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t pow;
        acc = '0;
        pow = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc ^= pow;
            pow = gf_xtime2(pow);
        end
        return acc;
    endfunction

    // Inverse as a^254, so zero comes out as zero
    function automatic aes_byte_t gf_inv(aes_byte_t a);
        aes_byte_t res;
        aes_byte_t sq;
        res = 8'h01;
        sq  = gf_mul(a, a);                 // a^2
        for (int i = 1; i < 8; i++) begin
            res = gf_mul(res, sq);          // Collects a^2 .. a^128
            sq  = gf_mul(sq, sq);
        end
        return res;
    endfunction

    function automatic aes_byte_t affine_fwd(aes_byte_t a);
        return a ^ rotl(a, 1) ^ rotl(a, 2) ^ rotl(a, 3) ^ rotl(a, 4) ^ 8'h63;
    endfunction

    function automatic aes_byte_t affine_inv(aes_byte_t a);
        return rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05;
    endfunction

    // One inverter shared by both directions
    assign pre_inv  = inv ? affine_inv(in) : in;
    assign inverted = gf_inv(pre_inv);

    // Affine step only on the forward path
    assign out = inv ? inverted : affine_fwd(inverted);

endmodule

//--- design/aes_types_pkg.sv
// AES arithmetic types and GF(2^8) helper functions
package aes_types_pkg;

    typedef logic [7:0]      aes_byte_t;
    typedef aes_byte_t [3:0] aes_word_t;   // Byte 0 sits in bits 7:0
    typedef logic [1:0]      aes_step_t;   // Unit step counter, 0 to 3

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aes_byte_t gf_xtime2(aes_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_byte_t gf_xtime3(aes_byte_t a);
        return gf_xtime2(a) ^ a;
    endfunction

    // Multiply by a small constant, as used by the inverse MixColumns matrix
    function automatic aes_byte_t gf_xtimen(aes_byte_t a, logic [3:0] n);
        aes_byte_t acc;
        aes_byte_t pow;
        acc = '0;
        pow = a;
        for (int i = 0; i < 4; i++) begin
            if (n[i]) acc ^= pow;
            pow = gf_xtime2(pow);
        end
        return acc;
    endfunction

endpackage

//--- design/aes_unit.sv
// AES instruction engine doing byte substitution and MixColumns one byte per cycle
`timescale 1ns/1ps
module aes_unit import aes_types_pkg::*, cop_isa_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       aes_valid,
    input  logic [4:0] subclass,
    input  aes_word_t  aes_rs1,
    input  aes_word_t  aes_rs2,
    output logic       aes_done,
    output logic [3:0] rd_ben,
    output aes_word_t  rd_wdata
);

    logic sub_enc;
    logic sub_encrot;
    logic sub_dec;
    logic sub_decrot;
    logic mix_enc;
    logic mix_dec;
    logic sub_op;
    logic mix_op;
    logic op_valid;    // Known subclass presented
    logic enc_mode;
    logic rotate;

    aes_step_t  step;
    aes_step_t  step_p1;
    aes_step_t  step_p2;
    aes_step_t  step_p3;
    aes_byte_t  col [4];    // Operand column and substitution source bytes
    aes_byte_t  sbox_out;
    aes_byte_t  mix_enc_row;
    aes_byte_t  mix_dec_row;
    aes_byte_t  new_byte;
    logic [3:0] pos_ben;    // Result byte written this step
    aes_word_t  tmp_reg;

    assign sub_enc    = subclass == sclass_sub_enc;
    assign sub_encrot = subclass == sclass_sub_encrot;
    assign sub_dec    = subclass == sclass_sub_dec;
    assign sub_decrot = subclass == sclass_sub_decrot;
    assign mix_enc    = subclass == sclass_mix_enc;
    assign mix_dec    = subclass == sclass_mix_dec;

    assign sub_op   = sub_enc || sub_encrot || sub_dec || sub_decrot;
    assign mix_op   = mix_enc || mix_dec;
    assign op_valid = aes_valid && (sub_op || mix_op);
    assign enc_mode = sub_enc || sub_encrot || mix_enc;
    assign rotate   = sub_encrot || sub_decrot;

    assign step_p1 = step + 2'd1;
    assign step_p2 = step + 2'd2;
    assign step_p3 = step + 2'd3;

    // Even bytes from rs1, odd bytes from rs2
    assign col[0] = aes_rs1[0];
    assign col[1] = aes_rs2[1];
    assign col[2] = aes_rs1[2];
    assign col[3] = aes_rs2[3];

    aes_sbox u_sbox (
        .in  (col[step]),
        .inv (!enc_mode),
        .out (sbox_out)
    );

    // Row k of the matrix is the row 0 pattern rotated by k
    assign mix_enc_row = gf_xtime2(col[step]) ^ gf_xtime3(col[step_p1]) ^
                         col[step_p2] ^ col[step_p3];
    assign mix_dec_row = gf_xtimen(col[step], 4'he) ^ gf_xtimen(col[step_p1], 4'hb) ^
                         gf_xtimen(col[step_p2], 4'hd) ^ gf_xtimen(col[step_p3], 4'h9);

    assign new_byte = mix_op ? (enc_mode ? mix_enc_row : mix_dec_row) : sbox_out;

    always_comb begin
        if (mix_op)
            pos_ben = 4'b1000 >> step;      // Row k lands in byte 3-k
        else if (rotate)
            pos_ben = 4'b0001 << step_p1;   // Top byte wraps to byte 0
        else
            pos_ben = 4'b0001 << step;
    end

    // Fresh byte merged over the partial result
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rd_wdata[b] = pos_ben[b] ? new_byte : tmp_reg[b];
        end
    end

    assign aes_done = op_valid && step == 2'd3;
    assign rd_ben   = {4{aes_done}};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step    <= '0;
            tmp_reg <= '0;
        end else if (op_valid) begin
            step    <= step_p1;    // Wraps to 0 after the last step
            tmp_reg <= rd_wdata;
        end
    end

    // Operation must not change under the engine mid-flight
    a_subclass_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        aes_valid && !aes_done ##1 aes_valid |-> $stable(subclass));

endmodule

//--- design/cop_decode.sv
// Instruction decoder that splits fields, steers AES work and retires illegal classes
`timescale 1ns/1ps
module cop_decode import cop_isa_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output cop_instr_t  dec,
    output logic        aes_valid,
    output logic        illegal_done
);

    logic illegal_seen;    // Illegal instruction already retired

    assign dec = '{cls:      instr[31:28],
                   subclass: instr[27:23],
                   rd:       instr[11:8],
                   rs1:      instr[3:0],
                   rs2:      instr[7:4],
                   spare:    instr[15:12]};

    assign aes_valid    = instr_valid && dec.cls == cls_aes;
    assign illegal_done = instr_valid && dec.cls != cls_aes && !illegal_seen;

    // Held until the host drops instr_valid
    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            illegal_seen <= 1'b0;
        else
            illegal_seen <= illegal_done || (illegal_seen && instr_valid);
    end

endmodule

//--- design/cop_isa_pkg.sv
// Co-processor instruction set: class and subclass codes, decoded instruction fields
package cop_isa_pkg;

    // Instruction class of the AES group
    localparam logic [3:0] cls_aes = 4'b0110;

    // AES subclasses
    localparam logic [4:0] sclass_sub_enc    = 5'b00001;  // SubBytes
    localparam logic [4:0] sclass_sub_encrot = 5'b00010;  // SubBytes, rotated placement
    localparam logic [4:0] sclass_sub_dec    = 5'b00011;  // InvSubBytes
    localparam logic [4:0] sclass_sub_decrot = 5'b00100;  // InvSubBytes, rotated placement
    localparam logic [4:0] sclass_mix_enc    = 5'b00101;  // One MixColumns column
    localparam logic [4:0] sclass_mix_dec    = 5'b00110;  // One InvMixColumns column

    // Instruction word layout
    //   [31:28] class
    //   [27:23] subclass
    //   [15:12] spare, ignored
    //   [11:8]  rd
    //   [7:4]   rs2
    //   [3:0]   rs1
    // The remaining bits are don't care

    typedef struct packed {
        logic [3:0] cls;
        logic [4:0] subclass;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic [3:0] spare;     // Carried along, no function
    } cop_instr_t;

endpackage

//--- design/cop_regfile.sv
// Co-processor register file: two read ports, byte writeback and host access
`timescale 1ns/1ps
module cop_regfile import aes_types_pkg::*; #(
    parameter int nregs = 16
) (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic [$clog2(nregs)-1:0] rs1_addr,
    input  logic [$clog2(nregs)-1:0] rs2_addr,
    input  logic [$clog2(nregs)-1:0] rd_addr,
    output aes_word_t                rs1_data,
    output aes_word_t                rs2_data,
    input  logic [3:0]               rd_ben,
    input  aes_word_t                rd_wdata,
    input  logic                     host_we,
    input  logic [$clog2(nregs)-1:0] host_addr,
    input  aes_word_t                host_wdata,
    input  logic [$clog2(nregs)-1:0] host_raddr,
    output aes_word_t                host_rdata
);

    aes_word_t regs [nregs];

    assign rs1_data   = regs[rs1_addr];
    assign rs2_data   = regs[rs2_addr];
    assign host_rdata = regs[host_raddr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < nregs; i++) regs[i] <= '0;
        end else begin
            if (host_we) regs[host_addr] <= host_wdata;
            // Later assignment, so writeback takes precedence
            for (int b = 0; b < 4; b++) begin
                if (rd_ben[b]) regs[rd_addr][b] <= rd_wdata[b];
            end
        end
    end

    a_no_collision: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(host_we && (|rd_ben) && host_addr == rd_addr));

endmodule

//--- design/cop_top.sv
// Co-processor slice: decoder, register file and AES unit
`timescale 1ns/1ps
module cop_top import cop_isa_pkg::*, aes_types_pkg::*; #(
    parameter int nregs = 16
) (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    output logic                     instr_done,
    input  logic                     host_we,
    input  logic [$clog2(nregs)-1:0] host_addr,
    input  aes_word_t                host_wdata,
    input  logic [$clog2(nregs)-1:0] host_raddr,
    output aes_word_t                host_rdata
);

    localparam int aw = $clog2(nregs);

    cop_instr_t dec;
    logic       aes_valid;
    logic       illegal_done;
    aes_word_t  aes_rs1;
    aes_word_t  aes_rs2;
    logic       aes_done;
    logic [3:0] rd_ben;
    aes_word_t  rd_wdata;

    assign instr_done = aes_done || illegal_done;

    cop_decode u_decode (
        .g_clk, .g_resetn, .instr_valid, .instr, .dec, .aes_valid, .illegal_done
    );

    cop_regfile #(.nregs(nregs)) u_regfile (
        .g_clk, .g_resetn,
        .rs1_addr (dec.rs1[aw-1:0]), .rs2_addr (dec.rs2[aw-1:0]),
        .rd_addr  (dec.rd[aw-1:0]),
        .rs1_data (aes_rs1), .rs2_data (aes_rs2),
        .rd_ben, .rd_wdata,
        .host_we, .host_addr, .host_wdata, .host_raddr, .host_rdata
    );

    aes_unit u_aes (
        .g_clk, .g_resetn, .aes_valid, .subclass (dec.subclass),
        .aes_rs1, .aes_rs2, .aes_done, .rd_ben, .rd_wdata
    );

endmodule

//--- project.f
design/cop_isa_pkg.sv
design/aes_types_pkg.sv
design/aes_sbox.sv
design/aes_unit.sv
design/cop_decode.sv
design/cop_regfile.sv
design/cop_top.sv
bench/tb_clkgen.sv
bench/tb_cop_top.sv
